// ==== design/pe_pkg.sv ====
// Sparse PE line shared definitions
// Sizes, activation beat and weight vector types
package pe_pkg;

    // ======================================================================
    // Sizes
    // ======================================================================

    // Blocks in the line
    localparam int NUM_PEB     = 4;
    // Channels per beat
    localparam int BLOCK_DEPTH = 4;
    // Signed activation and weight width
    localparam int DATA_WIDTH  = 8;
    // Full product width of one channel
    localparam int PROD_WIDTH  = 2 * DATA_WIDTH;
    // Signed psum width, wide enough that no saturation is needed
    localparam int PSUM_WIDTH  = 24;
    // Psum entries per block
    localparam int LENPSUM     = 8;
    localparam int ADDR_WIDTH  = $clog2(LENPSUM);

    // ======================================================================
    // Payload types
    // ======================================================================

    // Activation beat, 41 bits
    // Channel 0 sits in the low slice of acts
    typedef struct packed {
        logic [BLOCK_DEPTH-1:0][DATA_WIDTH-1:0] acts;
        logic [BLOCK_DEPTH-1:0]                 act_flags;
        logic [ADDR_WIDTH-1:0]                  col;
        logic                                   first;
        logic                                   last;
    } act_beat_t;

    // Weight vector of one block, 36 bits
    // Flag clear means the weight counts as zero
    typedef struct packed {
        logic [BLOCK_DEPTH-1:0][DATA_WIDTH-1:0] weis;
        logic [BLOCK_DEPTH-1:0]                 wei_flags;
    } wei_vec_t;

endpackage : pe_pkg

// ==== design/act_bus_if.sv ====
// Activation link between processing blocks
// One beat with a valid/ready handshake
`timescale 1ns/1ps

interface act_bus_if;
    import pe_pkg::*;

    // Transfer on an edge with valid and ready both high
    logic      valid;
    logic      ready;
    // Held stable by the source while valid waits on ready
    act_beat_t beat;

    // Upstream side, offers beats
    modport src (
        output valid,
        output beat,
        input  ready
    );

    // Downstream side, takes beats
    modport snk (
        input  valid,
        input  beat,
        output ready
    );

endinterface : act_bus_if

// ==== design/act_stage.sv ====
// Activation forwarding stage
// One register slot that moves beats one block down the line per cycle
`timescale 1ns/1ps

module act_stage (
    input  logic   clk,
    input  logic   arst_n,
    act_bus_if.snk in,
    act_bus_if.src out
);
    import pe_pkg::*;

    // ======================================================================
    // Slot state
    // ======================================================================

    // Slot occupied
    logic      full;
    // Held beat
    act_beat_t beat_q;
    // Beat enters the slot
    logic      push;
    // Beat leaves toward the next block
    logic      pop;

    // ======================================================================
    // Handshake
    // ======================================================================

    // Leaves when downstream takes it
    assign pop      = full && out.ready;

    // Room when empty or draining this cycle
    // Keeps one beat per cycle without a skid slot
    assign in.ready = !full || out.ready;
    assign push     = in.valid && in.ready;

    assign out.valid = full;
    assign out.beat  = beat_q;

    // Occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (push) begin
            full <= 1'b1;
        end else if (pop) begin
            full <= 1'b0;
        end
    end

    // Beat payload, visible downstream the cycle after acceptance
    always_ff @(posedge clk) begin
        if (push) begin
            beat_q <= in.beat;
        end
    end

endmodule : act_stage

// ==== design/sparse_mac.sv ====
// Flagged multiply-accumulate of one beat against one weight vector
// Products at the accept edge, sum one edge later, write request out
`timescale 1ns/1ps

module sparse_mac (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                start,
    input  pe_pkg::act_beat_t                   beat,
    input  pe_pkg::wei_vec_t                    weights,
    output logic                                wr_en,
    output logic [pe_pkg::ADDR_WIDTH-1:0]       wr_col,
    output logic                                wr_first,
    output logic                                wr_last,
    output logic signed [pe_pkg::PSUM_WIDTH-1:0] wr_sum,
    output logic                                busy
);
    import pe_pkg::*;

    // Per-channel products, before and after the stage one register
    logic signed [PROD_WIDTH-1:0] prod_d [BLOCK_DEPTH];
    logic signed [PROD_WIDTH-1:0] prod_q [BLOCK_DEPTH];
    // Stage one control and beat tags
    logic                         s1_valid;
    logic [ADDR_WIDTH-1:0]        s1_col;
    logic                         s1_first;
    logic                         s1_last;
    // Adder tree result
    logic signed [PSUM_WIDTH-1:0] sum_d;

    // ======================================================================
    // Stage one, flagged products
    // ======================================================================

    // Zero product unless both activation and weight are flagged
    always_comb begin
        for (int i = 0; i < BLOCK_DEPTH; i++) begin
            if (beat.act_flags[i] && weights.wei_flags[i]) begin
                prod_d[i] = $signed(beat.acts[i]) * $signed(weights.weis[i]);
            end else begin
                prod_d[i] = '0;
            end
        end
    end

    // ======================================================================
    // Stage two, channel sum
    // ======================================================================

    // Sign extended into the psum width
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < BLOCK_DEPTH; i++) begin
            sum_d = sum_d + prod_q[i];
        end
    end

    // Pipeline valids
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            wr_en    <= 1'b0;
        end else begin
            s1_valid <= start;
            wr_en    <= s1_valid;
        end
    end

    // Payload registers, loaded only with a valid beat
    always_ff @(posedge clk) begin
        if (start) begin
            prod_q   <= prod_d;
            s1_col   <= beat.col;
            s1_first <= beat.first;
            s1_last  <= beat.last;
        end
        if (s1_valid) begin
            wr_sum   <= sum_d;
            wr_col   <= s1_col;
            wr_first <= s1_first;
            wr_last  <= s1_last;
        end
    end

    // Any beat still in flight
    assign busy = s1_valid || wr_en;

endmodule : sparse_mac

// ==== design/psum_buffer.sv ====
// Partial-sum memory of one block
// Overwrite or add on write, registered read for the pool
`timescale 1ns/1ps

module psum_buffer (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 wr_en,
    input  logic [pe_pkg::ADDR_WIDTH-1:0]        wr_col,
    input  logic                                 wr_first,
    input  logic signed [pe_pkg::PSUM_WIDTH-1:0] wr_sum,
    input  logic                                 rd_en,
    input  logic [pe_pkg::ADDR_WIDTH-1:0]        rd_addr,
    output logic signed [pe_pkg::PSUM_WIDTH-1:0] rd_data
);
    import pe_pkg::*;

    // ======================================================================
    // Storage
    // ======================================================================

    // One entry per column
    logic signed [PSUM_WIDTH-1:0] mem [LENPSUM];
    // Value going into the addressed entry
    logic signed [PSUM_WIDTH-1:0] wr_val;

    // First beat of a frame starts the entry fresh
    // Later beats accumulate
    assign wr_val = wr_first ? wr_sum : mem[wr_col] + wr_sum;

    // Entries start at zero out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < LENPSUM; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_col] <= wr_val;
        end
    end

    // ======================================================================
    // Pool read port
    // ======================================================================

    // Data valid the cycle after rd_en
    // Same-column write in the same cycle returns the old entry
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule : psum_buffer

// ==== design/pe_block.sv ====
// Sparse processing block
// Weights, flagged MAC, psum buffer and beat forwarding to the next block
`timescale 1ns/1ps

module pe_block (
    input  logic                                 clk,
    input  logic                                 arst_n,
    act_bus_if.snk                               up,
    act_bus_if.src                               down,
    input  logic                                 wei_valid,
    output logic                                 wei_ready,
    input  pe_pkg::wei_vec_t                     wei_data,
    output logic                                 pool_en,
    input  logic                                 pool_rd_en,
    input  logic [pe_pkg::ADDR_WIDTH-1:0]        pool_rd_addr,
    output logic signed [pe_pkg::PSUM_WIDTH-1:0] pool_rd_data
);
    import pe_pkg::*;

    // Weight register and its state
    wei_vec_t                     wei_q;
    logic                         wei_loaded;
    logic                         wei_load;
    // Low only in reset and the cycle of release
    logic                         ready_en;
    // Beat handshake
    logic                         mac_free;
    logic                         take;
    // MAC to buffer
    logic                         mac_busy;
    logic                         wr_en;
    logic [ADDR_WIDTH-1:0]        wr_col;
    logic                         wr_first;
    logic                         wr_last;
    logic signed [PSUM_WIDTH-1:0] wr_sum;

    // Link into the forwarding stage
    act_bus_if fwd ();

    // ======================================================================
    // Weights
    // ======================================================================

    // Empty block or finished frame with nothing left in the MAC
    assign wei_ready = ready_en && (!wei_loaded || (pool_en && !mac_busy));
    assign wei_load  = wei_valid && wei_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_en   <= 1'b0;
            wei_loaded <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (wei_load) begin
                wei_loaded <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wei_load) begin
            wei_q <= wei_data;
        end
    end

    // ======================================================================
    // Consume and forward
    // ======================================================================

    // MAC reads the weight register live
    // No beat enters on the cycle the weights change
    assign mac_free = !wei_load;

    // Beat goes to the MAC and the forward stage on one handshake
    assign fwd.valid = up.valid && wei_loaded && mac_free;
    assign fwd.beat  = up.beat;
    // Stays low until weights are in, which stalls the whole line upstream
    assign up.ready  = wei_loaded && mac_free && fwd.ready;
    assign take      = fwd.valid && fwd.ready;

    act_stage u_stage (
        .clk    (clk),
        .arst_n (arst_n),
        .in     (fwd),
        .out    (down)
    );

    sparse_mac u_mac (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (take),
        .beat     (up.beat),
        .weights  (wei_q),
        .wr_en    (wr_en),
        .wr_col   (wr_col),
        .wr_first (wr_first),
        .wr_last  (wr_last),
        .wr_sum   (wr_sum),
        .busy     (mac_busy)
    );

    psum_buffer u_psum (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .wr_col   (wr_col),
        .wr_first (wr_first),
        .wr_sum   (wr_sum),
        .rd_en    (pool_rd_en),
        .rd_addr  (pool_rd_addr),
        .rd_data  (pool_rd_data)
    );

    // ======================================================================
    // Frame tracking
    // ======================================================================

    // Rises the cycle after the last beat lands in the buffer
    // Falls when the next frame's first beat is taken
    // A landing last beat wins over a same-edge first beat
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pool_en <= 1'b0;
        end else if (wr_en && wr_last) begin
            pool_en <= 1'b1;
        end else if (take && up.beat.first) begin
            pool_en <= 1'b0;
        end
    end

endmodule : pe_block

// ==== design/pe_line.sv ====
// Sparse PE line top level
// Chains the processing blocks and fans out the pool read bus
`timescale 1ns/1ps

module pe_line (
    input  logic                                          clk,
    input  logic                                          arst_n,
    // Activation input into block 0
    input  logic                                          act_valid,
    output logic                                          act_ready,
    input  pe_pkg::act_beat_t                             act_beat,
    // Per-block weight handshake, shared data
    input  logic [pe_pkg::NUM_PEB-1:0]                    wei_valid,
    output logic [pe_pkg::NUM_PEB-1:0]                    wei_ready,
    input  pe_pkg::wei_vec_t                              wei_data,
    // Pool side
    output logic [pe_pkg::NUM_PEB-1:0]                    pool_en,
    input  logic                                          pool_rd_en,
    input  logic [pe_pkg::ADDR_WIDTH-1:0]                 pool_rd_addr,
    output logic [pe_pkg::NUM_PEB*pe_pkg::PSUM_WIDTH-1:0] pool_rd_data
);
    import pe_pkg::*;

    // ======================================================================
    // Links
    // ======================================================================

    // Link k feeds block k, link NUM_PEB leaves the last block
    act_bus_if link [0:NUM_PEB] ();

    // Head of the chain from the plain ports
    assign link[0].valid = act_valid;
    assign link[0].beat  = act_beat;
    assign act_ready     = link[0].ready;

    // End of line, beats out of the last block are dropped
    assign link[NUM_PEB].ready = 1'b1;

    // ======================================================================
    // Blocks
    // ======================================================================

    // Block k reads pool slice k, lowest slice is block 0
    for (genvar k = 0; k < NUM_PEB; k++) begin : g_peb
        pe_block u_peb (
            .clk          (clk),
            .arst_n       (arst_n),
            .up           (link[k]),
            .down         (link[k+1]),
            .wei_valid    (wei_valid[k]),
            .wei_ready    (wei_ready[k]),
            .wei_data     (wei_data),
            .pool_en      (pool_en[k]),
            .pool_rd_en   (pool_rd_en),
            .pool_rd_addr (pool_rd_addr),
            .pool_rd_data (pool_rd_data[k*PSUM_WIDTH +: PSUM_WIDTH])
        );
    end

endmodule : pe_line

// ==== bench/pe_line_checker.sv ====
// Handshake and reset checks for the sparse PE line
// Bound into the line top level
`timescale 1ns/1ps

module pe_line_checker (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       act_valid,
    input  logic                       act_ready,
    input  pe_pkg::act_beat_t          act_beat,
    input  logic [pe_pkg::NUM_PEB-1:0] wei_valid,
    input  logic [pe_pkg::NUM_PEB-1:0] wei_ready,
    input  logic [pe_pkg::NUM_PEB-1:0] pool_en
);

    // Block 0 has taken a weight vector since reset
    logic blk0_loaded;
    // Assertion failures so far
    int   fail_count = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            blk0_loaded <= 1'b0;
        end else if (wei_valid[0] && wei_ready[0]) begin
            blk0_loaded <= 1'b1;
        end
    end

    // Offered beat waits unchanged for ready
    hold_beat: assert property (@(posedge clk) disable iff (!arst_n)
        act_valid && !act_ready |=> act_valid && $stable(act_beat))
        else begin
            fail_count++;
            $error("activation beat dropped or changed under back-pressure");
        end

    // Nothing offered to the pool or weight side in reset
    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (pool_en == '0) && (wei_ready == '0))
        else begin
            fail_count++;
            $error("pool_en or wei_ready high during reset");
        end

    // Line stalls until block 0 has weights
    ready_needs_weights: assert property (@(posedge clk) disable iff (!arst_n)
        act_ready |-> blk0_loaded)
        else begin
            fail_count++;
            $error("act_ready high before block 0 loaded weights");
        end

endmodule : pe_line_checker

// ==== bench/pe_line_tb.sv ====
// Testbench for the sparse PE line
// Frame table applied to the DUT and checked against a psum reference model
`timescale 1ns/1ps

module pe_line_tb;
    import pe_pkg::*;

    // ======================================================================
    // Table sizes and run limit
    // ======================================================================

    localparam int NUM_FRAMES = 3;
    localparam int NUM_ROWS   = 16;
    localparam int MAX_GAP    = 3;
    // Doubled worst case of beats, loads, drains and pool reads
    localparam int LIMIT_NS   = 2 * 10 * (NUM_ROWS * (MAX_GAP + 3)
                                + NUM_FRAMES * (3 * NUM_PEB + LENPSUM + 10) + 10);

    // One beat of the table
    // Gap below zero picks a random gap
    typedef struct {
        int       frame;
        int       col;
        bit       first;
        bit       last;
        bit [3:0] flags;
        int       gap;
    } row_t;

    logic                          clk;
    logic                          arst_n;
    logic                          act_valid;
    logic                          act_ready;
    act_beat_t                     act_beat;
    logic [NUM_PEB-1:0]            wei_valid;
    logic [NUM_PEB-1:0]            wei_ready;
    wei_vec_t                      wei_data;
    logic [NUM_PEB-1:0]            pool_en;
    logic                          pool_rd_en;
    logic [ADDR_WIDTH-1:0]         pool_rd_addr;
    logic [NUM_PEB*PSUM_WIDTH-1:0] pool_rd_data;

    row_t                          rows [NUM_ROWS];
    int                            n_rows;
    wei_vec_t                      frame_wei [NUM_FRAMES][NUM_PEB];
    // Reference psums per block and column
    logic signed [PSUM_WIDTH-1:0]  ref_psum [NUM_PEB][LENPSUM];
    int                            errors;

    pe_line pe_line_inst (.*);

    bind pe_line pe_line_checker u_checker (.*);

    always #5 clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================

    // Step to 1 ns after the next rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic add_row(input int frame, input int col, input bit first, input bit last,
                           input bit [3:0] flags, input int gap);
        rows[n_rows] = '{frame, col, first, last, flags, gap};
        n_rows++;
    endtask

    // Sum over channels flagged on both sides
    function automatic logic signed [PSUM_WIDTH-1:0] flagged_dot(input act_beat_t b,
                                                               input wei_vec_t w);
        int acc;
        int a;
        int wv;
        acc = 0;
        for (int i = 0; i < BLOCK_DEPTH; i++) begin
            a  = $signed(b.acts[i]);
            wv = $signed(w.weis[i]);
            if (b.act_flags[i] && w.wei_flags[i]) begin
                acc += a * wv;
            end
        end
        return acc[PSUM_WIDTH-1:0];
    endfunction

    // Nonzero activations so a clear flag really has to mask the channel
    function automatic act_beat_t make_beat(input row_t r);
        act_beat_t b;
        for (int i = 0; i < BLOCK_DEPTH; i++) begin
            b.acts[i] = DATA_WIDTH'($urandom % 255 + 1);
        end
        b.act_flags = r.flags;
        b.col       = ADDR_WIDTH'(r.col);
        b.first     = r.first;
        b.last      = r.last;
        return b;
    endfunction

    task automatic load_weights(input int k, input wei_vec_t w);
        wei_valid[k] = 1'b1;
        wei_data     = w;
        do @(negedge clk); while (!wei_ready[k]);
        tick();
        wei_valid[k] = 1'b0;
    endtask

    // Offer until taken and then apply the accumulation rule in the model
    task automatic offer_beat(input act_beat_t b, input int frame);
        act_beat  = b;
        act_valid = 1'b1;
        do @(negedge clk); while (!act_ready);
        tick();
        act_valid = 1'b0;
        for (int k = 0; k < NUM_PEB; k++) begin
            if (b.first) begin
                ref_psum[k][b.col] = flagged_dot(b, frame_wei[frame][k]);
            end else begin
                ref_psum[k][b.col] += flagged_dot(b, frame_wei[frame][k]);
            end
        end
    endtask

    // Wait for frame end in every block before reading all columns
    task automatic read_pool();
        do @(negedge clk); while (pool_en !== {NUM_PEB{1'b1}});
        tick();
        for (int c = 0; c < LENPSUM; c++) begin
            pool_rd_en   = 1'b1;
            pool_rd_addr = ADDR_WIDTH'(c);
            tick();
            for (int k = 0; k < NUM_PEB; k++) begin
                compare_value($sformatf("pool_rd_data[%0d] col %0d", k, c),
                              $unsigned(ref_psum[k][c]),
                              pool_rd_data[k*PSUM_WIDTH +: PSUM_WIDTH]);
            end
        end
        pool_rd_en = 1'b0;
    endtask

    // ======================================================================
    // Frame table
    // ======================================================================

    task automatic build_table();
        // Single-beat frame per column with one column fully masked
        add_row(0, 0, 1, 0, 4'b1111, 0);
        add_row(0, 1, 1, 0, 4'b0101, 0);
        add_row(0, 2, 1, 0, 4'b0000, 0);
        add_row(0, 3, 1, 1, 4'b1010, 0);
        // Accumulate and then overwrite column 2 mid-frame
        add_row(1, 2, 1, 0, 4'b1111, 1);
        add_row(1, 2, 0, 0, 4'b0111, 0);
        add_row(1, 5, 1, 0, 4'b1100, 2);
        add_row(1, 2, 1, 0, 4'b1011, 0);
        add_row(1, 2, 0, 0, 4'b1111, 1);
        add_row(1, 5, 0, 1, 4'b0011, 0);
        // Random gaps
        add_row(2, 0, 1, 0, 4'b1111, -1);
        add_row(2, 1, 1, 0, 4'b1001, -1);
        add_row(2, 0, 0, 0, 4'b0110, -1);
        add_row(2, 1, 0, 0, 4'b1111, -1);
        add_row(2, 0, 0, 0, 4'b1101, -1);
        add_row(2, 6, 1, 1, 4'b1110, -1);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        act_beat_t b;
        int        gap;
        int        assert_fails;
        clk          = 1'b0;
        arst_n       = 1'b0;
        act_valid    = 1'b0;
        act_beat     = '0;
        wei_valid    = '0;
        wei_data     = '0;
        pool_rd_en   = 1'b0;
        pool_rd_addr = '0;
        errors       = 0;
        n_rows       = 0;
        void'($urandom(32'h5c24_6ef1));
        build_table();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int k = 0; k < NUM_PEB; k++) begin
                frame_wei[f][k] = {32'($urandom), 4'($urandom)};
            end
        end
        for (int k = 0; k < NUM_PEB; k++) begin
            for (int c = 0; c < LENPSUM; c++) begin
                ref_psum[k][c] = '0;
            end
        end

        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        tick();
        compare_value("act_ready", 0, act_ready);
        compare_value("pool_en", 0, pool_en);
        compare_value("wei_ready", {NUM_PEB{1'b1}}, wei_ready);

        // First beat waits while weights load from the far end
        b = make_beat(rows[0]);
        act_beat  = b;
        act_valid = 1'b1;
        for (int k = NUM_PEB - 1; k >= 0; k--) begin
            compare_value("act_ready", 0, act_ready);
            load_weights(k, frame_wei[0][k]);
        end

        for (int r = 0; r < n_rows; r++) begin
            if (r > 0 && rows[r].frame != rows[r-1].frame) begin
                // Reload while the previous frame is still up for pooling
                for (int k = 0; k < NUM_PEB; k++) begin
                    load_weights(k, frame_wei[rows[r].frame][k]);
                end
                compare_value("pool_en", {NUM_PEB{1'b1}}, pool_en);
            end
            if (r > 0) begin
                gap = (rows[r].gap < 0) ? int'($urandom % (MAX_GAP + 1)) : rows[r].gap;
                repeat (gap) tick();
                b = make_beat(rows[r]);
            end
            offer_beat(b, rows[r].frame);
            if (rows[r].first) begin
                compare_value("pool_en[0]", 0, pool_en[0]);
            end
            if (rows[r].last) begin
                read_pool();
            end
        end

        assert_fails = pe_line_inst.u_checker.fail_count;
        $display("Run complete: %0d compare errors, %0d assertion failures over %0d beats",
                 errors, assert_fails, n_rows);
        if (errors == 0 && assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(LIMIT_NS);
        $display("Timeout: the table did not complete within %0d ns", LIMIT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule : pe_line_tb

// ==== verilog.f ====
design/pe_pkg.sv
design/act_bus_if.sv
design/act_stage.sv
design/sparse_mac.sv
design/psum_buffer.sv
design/pe_block.sv
design/pe_line.sv
bench/pe_line_checker.sv
bench/pe_line_tb.sv
